//--- compile.f
design/tlu_trig_pkg.sv
design/tlu_cfg_pkg.sv
design/tlu_reg_bank.sv
design/tlu_input_conditioner.sv
design/tlu_trigger_fsm.sv
design/tlu_trigger_counter.sv
design/tlu_event_fifo.sv
design/tlu_trigger_top.sv
tests/tlu_trigger_sva.sv
tests/tb_tlu_trigger.sv

//--- design/tlu_cfg_pkg.sv
// register map and configuration
// bus view of the trigger controller
package tlu_cfg_pkg;

    localparam logic [7:0] VERSION = 8'd8;

    // byte addresses, low nibble of the bus address
    localparam logic [3:0] ADDR_RESET          = 4'd0;  // read version, write soft reset
    localparam logic [3:0] ADDR_CONF           = 4'd1;  // bit 0 mode, bit 1 enable
    localparam logic [3:0] ADDR_TRIG_SELECT    = 4'd2;
    localparam logic [3:0] ADDR_VETO_SELECT    = 4'd3;
    localparam logic [3:0] ADDR_TRIG_INVERT    = 4'd4;
    localparam logic [3:0] ADDR_COUNT0         = 4'd5;  // live byte, latches buffer
    localparam logic [3:0] ADDR_COUNT1         = 4'd6;
    localparam logic [3:0] ADDR_COUNT2         = 4'd7;
    localparam logic [3:0] ADDR_COUNT3         = 4'd8;  // write loads the counter
    localparam logic [3:0] ADDR_COUNT_MAX0     = 4'd9;
    localparam logic [3:0] ADDR_COUNT_MAX1     = 4'd10;
    localparam logic [3:0] ADDR_COUNT_MAX2     = 4'd11;
    localparam logic [3:0] ADDR_COUNT_MAX3     = 4'd12;
    localparam logic [3:0] ADDR_LOST_CNT       = 4'd13;
    localparam logic [3:0] ADDR_ACCEPT_WAIT    = 4'd14;
    localparam logic [3:0] ADDR_ACCEPT_ERR_CNT = 4'd15;

    typedef struct packed {
        tlu_trig_pkg::tlu_mode_t mode;
        logic                    enable;
        logic [7:0]              trig_select;
        logic [7:0]              veto_select;
        logic [7:0]              trig_invert;
        logic [31:0]             count_max;   // 0 means no limit
        logic [7:0]              accept_wait; // TLU high cycles before accept
    } tlu_conf_t;

    localparam tlu_conf_t CONF_RESET = '{
        mode:        tlu_trig_pkg::MODE_STANDARD,
        enable:      1'b0,
        trig_select: 8'h00,
        veto_select: 8'h00,
        trig_invert: 8'h00,
        count_max:   32'd0,
        accept_wait: 8'd3
    };

endpackage

//--- design/tlu_event_fifo.sv
// trigger word FIFO
// show-ahead read, drops and counts on overflow
`timescale 1ns/10ps

module tlu_event_fifo #(
    parameter int FIFO_DEPTH = 8 // power of two
) (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic                    write,
    input  tlu_trig_pkg::tlu_word_t word,
    input  logic                    fifo_read,
    output logic                    fifo_empty,
    output tlu_trig_pkg::tlu_word_t fifo_data,
    output logic [7:0]              lost_cnt
);
    import tlu_trig_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    tlu_word_t        mem [FIFO_DEPTH];
    logic [PTR_W:0]   wr_ptr; // msb is the wrap bit
    logic [PTR_W:0]   rd_ptr;
    logic             full;
    logic             do_write;
    logic             do_read;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign full       = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                        && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign do_write   = write && !full;
    assign do_read    = fifo_read && !fifo_empty;

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr[PTR_W-1:0]] <= word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            lost_cnt <= 8'd0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            if (write && full && (lost_cnt != 8'hff))
                lost_cnt <= lost_cnt + 8'd1; // saturates at 255
        end
    end

    assign fifo_data = mem[rd_ptr[PTR_W-1:0]];

endmodule

//--- design/tlu_input_conditioner.sv
// trigger input conditioning
`timescale 1ns/10ps

module tlu_input_conditioner #(
    parameter int NUM_INPUTS = 8 // at most 8, one config byte per mask
) (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  logic [NUM_INPUTS-1:0]  trigger,
    input  logic [NUM_INPUTS-1:0]  trigger_veto,
    input  logic                   tlu_trigger,
    input  tlu_cfg_pkg::tlu_conf_t conf,
    output logic                   trig_sync,
    output logic                   veto_sync,
    output logic                   tlu_sync
);

    logic       trig_or;
    logic       veto_or;
    logic [2:0] sync_s1; // {tlu, veto, trig}
    logic [2:0] sync_s2;
    logic [2:0] sync_s3;

    // invert first, then mask and OR
    assign trig_or = |((trigger ^ conf.trig_invert[NUM_INPUTS-1:0])
                       & conf.trig_select[NUM_INPUTS-1:0]);
    assign veto_or = |(trigger_veto & conf.veto_select[NUM_INPUTS-1:0]);

    // three flops per line, pins are asynchronous
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            sync_s1 <= 3'b000;
            sync_s2 <= 3'b000;
            sync_s3 <= 3'b000;
        end
        else
        begin
            sync_s1 <= {tlu_trigger, veto_or, trig_or};
            sync_s2 <= sync_s1;
            sync_s3 <= sync_s2;
        end
    end

    assign {tlu_sync, veto_sync, trig_sync} = sync_s3;

endmodule

//--- design/tlu_reg_bank.sv
// register bank
// byte bus decode, configuration and readback
`timescale 1ns/10ps

module tlu_reg_bank #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic [ADDR_WIDTH-1:0]   bus_add,
    input  logic [7:0]              bus_data_in,
    input  logic                    bus_wr,
    input  logic                    bus_rd,
    output logic [7:0]              bus_data_out,
    input  tlu_trig_pkg::tlu_status_t status,
    output tlu_cfg_pkg::tlu_conf_t  conf,
    output logic                    count_load,
    output logic [31:0]             count_value,
    output logic                    soft_rst
);
    import tlu_cfg_pkg::*;
    import tlu_trig_pkg::*;

    logic        in_range;
    logic [3:0]  reg_addr;
    logic        wr_en;
    logic        rd_en;
    logic [23:0] count_stage;  // bytes 0..2 of the preset value
    logic [31:0] count_buf;    // snapshot for a consistent 4-byte read
    logic [7:0]  rd_mux;

    assign in_range = (bus_add[ADDR_WIDTH-1:4] == '0);
    assign reg_addr = bus_add[3:0];
    assign wr_en    = bus_wr && in_range;
    assign rd_en    = bus_rd && in_range;

    // preset goes out at the edge of the top byte write
    assign count_load  = wr_en && (reg_addr == ADDR_COUNT3);
    assign count_value = {bus_data_in, count_stage};

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            conf     <= CONF_RESET;
            soft_rst <= 1'b0;
        end
        else
        begin
            soft_rst <= wr_en && (reg_addr == ADDR_RESET); // one cycle after the write
            if (wr_en)
            begin
                case (reg_addr)
                    ADDR_CONF:
                    begin
                        conf.mode   <= tlu_mode_t'(bus_data_in[0]);
                        conf.enable <= bus_data_in[1];
                    end
                    ADDR_TRIG_SELECT: conf.trig_select        <= bus_data_in;
                    ADDR_VETO_SELECT: conf.veto_select        <= bus_data_in;
                    ADDR_TRIG_INVERT: conf.trig_invert        <= bus_data_in;
                    ADDR_COUNT_MAX0:  conf.count_max[7:0]     <= bus_data_in;
                    ADDR_COUNT_MAX1:  conf.count_max[15:8]    <= bus_data_in;
                    ADDR_COUNT_MAX2:  conf.count_max[23:16]   <= bus_data_in;
                    ADDR_COUNT_MAX3:  conf.count_max[31:24]   <= bus_data_in;
                    ADDR_ACCEPT_WAIT: conf.accept_wait        <= bus_data_in;
                    default: ;
                endcase
            end
        end
    end

    // staging bytes for the counter preset
    always_ff @(posedge BUS_CLK)
    begin
        if (wr_en)
        begin
            case (reg_addr)
                ADDR_COUNT0: count_stage[7:0]   <= bus_data_in;
                ADDR_COUNT1: count_stage[15:8]  <= bus_data_in;
                ADDR_COUNT2: count_stage[23:16] <= bus_data_in;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        case (reg_addr)
            ADDR_RESET:          rd_mux = VERSION;
            ADDR_CONF:           rd_mux = {6'b0, conf.enable, conf.mode};
            ADDR_TRIG_SELECT:    rd_mux = conf.trig_select;
            ADDR_VETO_SELECT:    rd_mux = conf.veto_select;
            ADDR_TRIG_INVERT:    rd_mux = conf.trig_invert;
            ADDR_COUNT0:         rd_mux = status.trigger_count[7:0]; // live value
            ADDR_COUNT1:         rd_mux = count_buf[15:8];
            ADDR_COUNT2:         rd_mux = count_buf[23:16];
            ADDR_COUNT3:         rd_mux = count_buf[31:24];
            ADDR_COUNT_MAX0:     rd_mux = conf.count_max[7:0];
            ADDR_COUNT_MAX1:     rd_mux = conf.count_max[15:8];
            ADDR_COUNT_MAX2:     rd_mux = conf.count_max[23:16];
            ADDR_COUNT_MAX3:     rd_mux = conf.count_max[31:24];
            ADDR_LOST_CNT:       rd_mux = status.lost_cnt;
            ADDR_ACCEPT_WAIT:    rd_mux = conf.accept_wait;
            ADDR_ACCEPT_ERR_CNT: rd_mux = status.accept_err_cnt;
        endcase
    end

    // registered read data, held until the next read
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            bus_data_out <= 8'h00;
            count_buf    <= 32'd0;
        end
        else if (bus_rd)
        begin
            bus_data_out <= in_range ? rd_mux : 8'h00; // unmapped reads give 0
            if (rd_en && (reg_addr == ADDR_COUNT0))
                count_buf <= status.trigger_count;
        end
    end

endmodule

//--- design/tlu_trig_pkg.sv
// trigger path types
// modes, FSM states, trigger word and status
package tlu_trig_pkg;

    // trigger source selection
    typedef enum logic {
        MODE_STANDARD      = 1'b0,
        MODE_TLU_HANDSHAKE = 1'b1
    } tlu_mode_t;

    // acceptance FSM states
    typedef enum logic [1:0] {
        ST_IDLE         = 2'd0,
        ST_WAIT_ACCEPT  = 2'd1, // TLU line must stay high
        ST_ACCEPTED     = 2'd2, // one cycle, accepted pulse
        ST_WAIT_RELEASE = 2'd3
    } tlu_state_t;

    // word pushed into the event FIFO
    typedef struct packed {
        logic        marker;          // always set
        logic [30:0] trigger_number;
    } tlu_word_t;

    // counters shown on the register bus
    typedef struct packed {
        logic [31:0] trigger_count;
        logic [7:0]  lost_cnt;        // saturating
        logic [7:0]  accept_err_cnt;  // saturating
    } tlu_status_t;

endpackage

//--- design/tlu_trigger_counter.sv
// trigger counter and accept-error count
`timescale 1ns/10ps

module tlu_trigger_counter (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  tlu_cfg_pkg::tlu_conf_t  conf,
    input  logic                    accepted,
    input  logic                    accept_err,
    input  logic                    count_load,
    input  logic [31:0]             count_value,
    output tlu_trig_pkg::tlu_word_t word,
    output logic [31:0]             trigger_count,
    output logic [7:0]              accept_err_cnt,
    output logic                    limit_reached
);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trigger_count  <= 32'd0;
            accept_err_cnt <= 8'd0;
            limit_reached  <= 1'b0;
        end
        else
        begin
            if (count_load)
                trigger_count <= count_value; // bus preset wins
            else if (accepted)
                trigger_count <= trigger_count + 32'd1;

            limit_reached <= (conf.count_max != 32'd0) && (trigger_count >= conf.count_max);

            if (accept_err && (accept_err_cnt != 8'hff))
                accept_err_cnt <= accept_err_cnt + 8'd1;
        end
    end

    // value before the increment goes into the FIFO
    assign word.marker         = 1'b1;
    assign word.trigger_number = trigger_count[30:0];

endmodule

//--- design/tlu_trigger_fsm.sv
// trigger acceptance FSM
// standard trigger and TLU simple handshake
`timescale 1ns/10ps

module tlu_trigger_fsm (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  tlu_cfg_pkg::tlu_conf_t conf,
    input  logic                   trig_sync,
    input  logic                   veto_sync,
    input  logic                   tlu_sync,
    input  logic                   limit_reached,
    output logic                   accepted,
    output logic                   accept_err,
    output logic                   tlu_busy
);
    import tlu_trig_pkg::*;

    tlu_state_t state;
    tlu_state_t state_next;
    logic [7:0] wait_cnt;   // high cycles of tlu_sync seen so far
    logic       tlu_mode;
    logic       armed;
    logic       start;
    logic       trig_level;
    logic       wait_done;

    assign tlu_mode   = (conf.mode == MODE_TLU_HANDSHAKE);
    assign armed      = conf.enable && !limit_reached;
    assign start      = tlu_mode ? tlu_sync : (trig_sync && !veto_sync); // no veto in TLU mode
    assign trig_level = tlu_mode ? tlu_sync : trig_sync;
    assign wait_done  = ({1'b0, wait_cnt} + 9'd1) >= {1'b0, conf.accept_wait};

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (armed && start)
                    state_next = tlu_mode ? ST_WAIT_ACCEPT : ST_ACCEPTED;
            end
            ST_WAIT_ACCEPT:
            begin
                if (!tlu_sync)
                    state_next = ST_IDLE; // dropped too early
                else if (wait_done)
                    state_next = ST_ACCEPTED;
            end
            ST_ACCEPTED:
                state_next = ST_WAIT_RELEASE;
            default:
            begin
                if (!trig_level)
                    state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state      <= ST_IDLE;
            wait_cnt   <= 8'd0;
            accept_err <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            accept_err <= (state == ST_WAIT_ACCEPT) && !tlu_sync;
            if (state == ST_IDLE)
                wait_cnt <= 8'd1; // the idle cycle already saw the line high
            else if (state == ST_WAIT_ACCEPT)
                wait_cnt <= wait_cnt + 8'd1;
        end
    end

    assign accepted = (state == ST_ACCEPTED);

    // busy back to the TLU until it drops its trigger line
    assign tlu_busy = tlu_mode && ((state == ST_ACCEPTED) || (state == ST_WAIT_RELEASE));

endmodule

//--- design/tlu_trigger_top.sv
// trigger controller top level
`timescale 1ns/10ps

module tlu_trigger_top #(
    parameter int ADDR_WIDTH = 16,
    parameter int NUM_INPUTS = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    BUS_CLK,
    input  logic                    RST,
    input  logic [ADDR_WIDTH-1:0]   bus_add,
    input  logic [7:0]              bus_data_in,
    input  logic                    bus_wr,
    input  logic                    bus_rd,
    output logic [7:0]              bus_data_out,
    input  logic [NUM_INPUTS-1:0]   trigger,
    input  logic [NUM_INPUTS-1:0]   trigger_veto,
    input  logic                    tlu_trigger,
    output logic                    tlu_busy,
    output logic                    trigger_accepted,
    input  logic                    fifo_read,
    output logic                    fifo_empty,
    output tlu_trig_pkg::tlu_word_t fifo_data
);
    import tlu_cfg_pkg::*;
    import tlu_trig_pkg::*;

    logic        rst_int;
    logic        soft_rst;
    tlu_conf_t   conf;
    tlu_status_t status;
    tlu_word_t   word;
    logic        count_load;
    logic [31:0] count_value;
    logic [31:0] trigger_count;
    logic [7:0]  lost_cnt;
    logic [7:0]  accept_err_cnt;
    logic        trig_sync;
    logic        veto_sync;
    logic        tlu_sync;
    logic        limit_reached;
    logic        accept_err;

    assign rst_int = RST | soft_rst; // soft reset acts like the pin
    assign status  = '{trigger_count: trigger_count, lost_cnt: lost_cnt,
                       accept_err_cnt: accept_err_cnt};

    tlu_reg_bank #(.ADDR_WIDTH(ADDR_WIDTH)) u_reg_bank (
        .BUS_CLK(BUS_CLK), .RST(rst_int),
        .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_wr(bus_wr), .bus_rd(bus_rd), .bus_data_out(bus_data_out),
        .status(status), .conf(conf),
        .count_load(count_load), .count_value(count_value),
        .soft_rst(soft_rst)
    );

    tlu_input_conditioner #(.NUM_INPUTS(NUM_INPUTS)) u_input_conditioner (
        .BUS_CLK(BUS_CLK), .RST(rst_int),
        .trigger(trigger), .trigger_veto(trigger_veto), .tlu_trigger(tlu_trigger),
        .conf(conf),
        .trig_sync(trig_sync), .veto_sync(veto_sync), .tlu_sync(tlu_sync)
    );

    tlu_trigger_fsm u_trigger_fsm (
        .BUS_CLK(BUS_CLK), .RST(rst_int), .conf(conf),
        .trig_sync(trig_sync), .veto_sync(veto_sync), .tlu_sync(tlu_sync),
        .limit_reached(limit_reached),
        .accepted(trigger_accepted), .accept_err(accept_err), .tlu_busy(tlu_busy)
    );

    tlu_trigger_counter u_trigger_counter (
        .BUS_CLK(BUS_CLK), .RST(rst_int), .conf(conf),
        .accepted(trigger_accepted), .accept_err(accept_err),
        .count_load(count_load), .count_value(count_value),
        .word(word), .trigger_count(trigger_count),
        .accept_err_cnt(accept_err_cnt), .limit_reached(limit_reached)
    );

    tlu_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_event_fifo (
        .BUS_CLK(BUS_CLK), .RST(rst_int),
        .write(trigger_accepted), .word(word),
        .fifo_read(fifo_read), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .lost_cnt(lost_cnt)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trigger controller testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_tlu_trigger \
    -f compile.f -o sim_tlu_trigger
./obj_dir/sim_tlu_trigger 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log
then
    exit 1
fi
exit 0

//--- tests/tb_tlu_trigger.sv
// trigger controller testbench
// stimulus and expected values from the golden file
`timescale 1ns/10ps

module tb_tlu_trigger;
    import tlu_trig_pkg::*;

    localparam int    ADDR_WIDTH     = 16;
    localparam int    NUM_INPUTS     = 8;
    localparam int    FIFO_DEPTH     = 8;
    localparam int    CLK_HALF       = 20;
    localparam int    CYCLES_PER_CMD = 200;
    localparam string GOLDEN         = "tests/tlu_trigger_golden.txt";

    logic                  BUS_CLK;
    logic                  RST;
    logic [ADDR_WIDTH-1:0] bus_add;
    logic [7:0]            bus_data_in;
    logic                  bus_wr;
    logic                  bus_rd;
    logic [7:0]            bus_data_out;
    logic [NUM_INPUTS-1:0] trigger;
    logic [NUM_INPUTS-1:0] trigger_veto;
    logic                  tlu_trigger;
    logic                  tlu_busy;
    logic                  trigger_accepted;
    logic                  fifo_read;
    logic                  fifo_empty;
    tlu_word_t             fifo_data;

    int    num_cmds;
    int    errors;
    int    test_errors;
    int    checks;
    int    tests_done;
    int    accept_pulses; // trigger_accepted cycles in this test
    int    words_popped;
    int    lost_words;    // from the expected lost count
    string test_name;
    bit    busy_expected; // armed by B, checked after the next H
    bit    busy_seen;

    tlu_trigger_top #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .NUM_INPUTS(NUM_INPUTS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tlu_trigger_top (
        .BUS_CLK(BUS_CLK), .RST(RST),
        .bus_add(bus_add), .bus_data_in(bus_data_in),
        .bus_wr(bus_wr), .bus_rd(bus_rd), .bus_data_out(bus_data_out),
        .trigger(trigger), .trigger_veto(trigger_veto), .tlu_trigger(tlu_trigger),
        .tlu_busy(tlu_busy), .trigger_accepted(trigger_accepted),
        .fifo_read(fifo_read), .fifo_empty(fifo_empty), .fifo_data(fifo_data)
    );

    always #(CLK_HALF) BUS_CLK = ~BUS_CLK;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            test_errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    // each cycle ends 2 ns after the rising edge
    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge BUS_CLK);
            #2;
            if (tlu_busy)
                busy_seen = 1'b1;
            if (trigger_accepted)
                accept_pulses++;
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        idle(1);
        bus_wr = 1'b0;
        idle(1); // a soft reset lands here
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic [7:0] expected);
        bus_add = addr;
        bus_rd  = 1'b1;
        idle(1);
        bus_rd = 1'b0;
        check($sformatf("bus_data_out[%0h]", addr), 32'(expected), 32'(bus_data_out));
    endtask

    task automatic pulse_triggers(input int count, input logic [7:0] mask,
                                  input logic [7:0] veto);
        trigger_veto = veto;
        repeat (count)
        begin
            trigger = mask;
            idle(8);
            trigger = '0;
            idle(12);
        end
        trigger_veto = '0;
    endtask

    task automatic hold_tlu(input int cycles);
        tlu_trigger = 1'b1;
        idle(cycles);
        tlu_trigger = 1'b0;
        idle(12); // busy drops a few cycles after the line
    endtask

    task automatic pop_word(input logic [31:0] expected);
        check("fifo_empty", 32'd0, 32'(fifo_empty));
        check("fifo_data", expected, fifo_data);
        fifo_read = 1'b1;
        idle(1);
        fifo_read = 1'b0;
        words_popped++;
    endtask

    // every accept gives one word, popped or dropped
    task automatic finish_test();
        if (test_name.len() > 0)
        begin
            check("trigger_accepted pulses", 32'(words_popped + lost_words),
                  32'(accept_pulses));
            tests_done++;
            $display("test %s done, %0d errors", test_name, test_errors);
        end
        test_errors   = 0;
        accept_pulses = 0;
        words_popped  = 0;
        lost_words    = 0;
    endtask

    // strip line end and trailing blanks
    function automatic string clean_line(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r[r.len()-1] == "\n" || r[r.len()-1] == "\r"
                               || r[r.len()-1] == " "))
            r = r.substr(0, r.len() - 2);
        return r;
    endfunction

    initial
    begin
        int          fd;
        string       line;
        string       args;
        logic [7:0]  cmd;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;

        BUS_CLK       = 1'b0;
        RST           = 1'b1;
        bus_add       = '0;
        bus_data_in   = 8'h00;
        bus_wr        = 1'b0;
        bus_rd        = 1'b0;
        trigger       = '0;
        trigger_veto  = '0;
        tlu_trigger   = 1'b0;
        fifo_read     = 1'b0;
        errors        = 0;
        test_errors   = 0;
        checks        = 0;
        tests_done    = 0;
        accept_pulses = 0;
        words_popped  = 0;
        lost_words    = 0;
        test_name     = "";

        // first pass only counts commands for the watchdog
        fd = $fopen(GOLDEN, "r");
        if (fd == 0)
        begin
            $display("cannot open golden file %s", GOLDEN);
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                line = clean_line(line);
                if (line.len() > 0 && line[0] != "#")
                    num_cmds++;
            end
            $fclose(fd);
            fd = $fopen(GOLDEN, "r");
        end

        repeat (3) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
        idle(1);
        check("trigger_accepted", 32'd0, 32'(trigger_accepted));
        check("tlu_busy", 32'd0, 32'(tlu_busy));
        check("bus_data_out", 32'd0, 32'(bus_data_out));
        check("fifo_empty", 32'd1, 32'(fifo_empty));

        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0)
            begin
                line = clean_line(line);
                if (line.len() == 0 || line[0] == "#")
                    continue;
                cmd  = line[0];
                args = line.substr(1, line.len() - 1);
                a1   = '0;
                a2   = '0;
                a3   = '0;
                void'($sscanf(args, "%h %h %h", a1, a2, a3));
                case (cmd)
                    "T":
                    begin
                        finish_test();
                        test_name = (args.len() > 1) ? args.substr(1, args.len() - 1)
                                                     : "unnamed";
                    end
                    "W": bus_write(a1[15:0], a2[7:0]);
                    "R":
                    begin
                        bus_read(a1[15:0], a2[7:0]);
                        if (a1[15:0] == 16'hd)
                            lost_words = int'(a2[7:0]); // dropped words were accepted too
                    end
                    "P": pulse_triggers(int'(a1), a2[7:0], a3[7:0]);
                    "H":
                    begin
                        hold_tlu(int'(a1));
                        if (busy_expected)
                            check("tlu_busy seen", 32'd1, 32'(busy_seen));
                        busy_expected = 1'b0;
                    end
                    "F": pop_word(a1);
                    "E": check("fifo_empty", 32'd1, 32'(fifo_empty));
                    "B":
                    begin
                        busy_expected = 1'b1;
                        busy_seen     = 1'b0;
                    end
                    default:
                    begin
                        errors++;
                        test_errors++;
                        $display("unknown golden command '%s' in test %s", line, test_name);
                    end
                endcase
            end
            $fclose(fd);
        end

        finish_test();
        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // run budget scales with the golden file
    initial
    begin
        wait (num_cmds > 0);
        #(num_cmds * CYCLES_PER_CMD * 2 * CLK_HALF);
        $display("watchdog expired, test %s did not finish in time", test_name);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- tests/tlu_trigger_golden.txt
# args in hex: T name | W addr data | R addr byte | P pulses trig_mask veto_mask
# H high_cycles | F word | E fifo empty | B tlu_busy expected during next H
T reset_values
R 0 08
R e 03
R 1 00
R 2 00
R 3 00
R 4 00
W 1 03
W 2 a5
W 3 5a
W 4 0f
R 1 03
R 2 a5
R 3 5a
R 4 0f
W 0 00
R 1 00
R 2 00
R 3 00
R 4 00
R e 03
T standard_trigger
W 0 00
W 2 05
W 1 02
P 1 01 00
P 1 04 00
P 1 02 00
W 3 01
P 1 01 01
W 3 00
W 2 07
W 4 02
P 1 01 00
W 4 00
R 5 03
R 6 00
R 7 00
R 8 00
F 80000000
F 80000001
F 80000002
E
T preset_limit
W 0 00
W 5 64
W 6 00
W 7 00
W 8 00
W 9 66
W 2 01
W 1 02
P 5 01 00
R 5 66
R 6 00
R 7 00
R 8 00
F 80000064
F 80000065
E
T tlu_handshake
W 0 00
W 1 03
B
H 14
F 80000000
E
H 2
E
R f 01
R 5 01
T fifo_overflow
W 0 00
W 2 01
W 1 02
P a 01 00
F 80000000
F 80000001
F 80000002
F 80000003
F 80000004
F 80000005
F 80000006
F 80000007
E
R d 02
R 5 0a

//--- tests/tlu_trigger_sva.sv
// trigger FSM assertions
`timescale 1ns/10ps

module tlu_trigger_sva (
    input logic                   BUS_CLK,
    input logic                   RST,
    input tlu_cfg_pkg::tlu_conf_t conf,
    input logic                   trig_sync,
    input logic                   tlu_sync,
    input logic                   accepted,
    input logic                   tlu_busy
);
    import tlu_trig_pkg::*;

    logic tlu_mode;
    logic trig_level;
    logic released;  // line seen low since the last accept

    assign tlu_mode   = (conf.mode == MODE_TLU_HANDSHAKE);
    assign trig_level = tlu_mode ? tlu_sync : trig_sync;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            released <= 1'b1;
        else if (accepted)
            released <= 1'b0;
        else if (!trig_level)
            released <= 1'b1;
    end

    // one accept per trigger, the next only after the line went low
    single_accept: assert property (@(posedge BUS_CLK) disable iff (RST)
        accepted |-> released)
        else $error("accepted again before the trigger line was released");

    busy_held: assert property (@(posedge BUS_CLK) disable iff (RST)
        tlu_busy && tlu_sync |=> tlu_busy || !tlu_mode)
        else $error("tlu_busy dropped while the TLU line was still high");

    busy_release: assert property (@(posedge BUS_CLK) disable iff (RST)
        tlu_busy && !tlu_sync && !accepted |=> !tlu_busy)
        else $error("tlu_busy still high after the TLU line fell");

endmodule

bind tlu_trigger_fsm tlu_trigger_sva u_fsm_sva (
    .BUS_CLK(BUS_CLK), .RST(RST), .conf(conf), .trig_sync(trig_sync),
    .tlu_sync(tlu_sync), .accepted(accepted), .tlu_busy(tlu_busy)
);
